// File: hw/l15_pkg.sv
// request and return codes, sizes and the decoded request type shared by the bridge and its testbench
`default_nettype none

package l15_pkg;

    // one core word on both sides
    localparam int addr_w = 32;
    localparam int data_w = 32;

    localparam int rqtype_w  = 5;
    localparam int rettype_w = 4;
    localparam int size_w    = 3;

    // request codes sent to the L1.5
    typedef enum logic [rqtype_w-1:0] {
        load_rq  = 5'b00000,
        store_rq = 5'b00001,
        rsvd_rq  = 5'b11111
    } l15_rqtype_e;

    // return codes seen on l15_core_returntype
    typedef enum logic [rettype_w-1:0] {
        load_ret = 4'b0000,
        st_ack   = 4'b0100,
        err_ret  = 4'b1100
    } l15_rettype_e;

    // message size, bytes carried by the request
    typedef enum logic [size_w-1:0] {
        size_0b = 3'b000,
        size_1b = 3'b001,
        size_2b = 3'b010,
        size_4b = 3'b011
    } msg_size_e;

    // one decoded request, data already in cache byte order
    typedef struct packed {
        l15_rqtype_e         rqtype;
        msg_size_e           size;
        logic [addr_w-1:0]   address;
        logic [data_w-1:0]   data;
    } l15_req_t;

    // core is little endian, the cache port big endian
    function automatic logic [data_w-1:0] swap_bytes(input logic [data_w-1:0] word);
        logic [data_w-1:0] result;
        for (int i = 0; i < data_w / 8; i++) begin
            result[8*i +: 8] = word[data_w - 8*(i+1) +: 8];
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: hw/bridge_if.sv
// internal links of the bridge, decode to FSM and FSM to the result stage
`timescale 1ns/1ps
`default_nettype none

// decoded memory operation, valid for the cycle of start
interface mem_op_if;
    import l15_pkg::*;

    logic     start;
    l15_req_t req;
    logic     is_store;
    logic     bad_be;

    modport decode (
        output start,
        output req,
        output is_store,
        output bad_be
    );

    modport fsm (
        input start,
        input req,
        input is_store,
        input bad_be
    );
endinterface

// raw cache response, valid in the cycle of capture
interface l15_resp_if;
    import l15_pkg::*;

    logic              capture;
    logic [data_w-1:0] data;
    l15_rettype_e      rettype;
    logic              is_store;

    modport fsm (
        output capture,
        output data,
        output rettype,
        output is_store
    );

    modport unpack (
        input capture,
        input data,
        input rettype,
        input is_store
    );
endinterface

`default_nettype wire

// File: hw/mem_req_decode.sv
// combinational decode of a core memory strobe into an L1.5 load or store request
`timescale 1ns/1ps
`default_nettype none

module mem_req_decode (
    input  logic [l15_pkg::addr_w-1:0] mem_addr,
    input  logic [l15_pkg::data_w-1:0] mem_wdata,
    input  logic                       mem_rd,
    input  logic [3:0]                 mem_bw,
    input  logic                       mem_op,
    input  logic                       busy,
    mem_op_if.decode                   op
);
    import l15_pkg::*;

    l15_rqtype_e rqtype;
    msg_size_e   size;
    logic        store;
    logic        bad;

    // byte enables pick the request, a read only matters when none are set
    always_comb begin
        rqtype = load_rq;
        size   = size_4b;
        store  = 1'b0;
        bad    = 1'b0;
        if (mem_bw != 4'b0000) begin
            rqtype = store_rq;
            store  = 1'b1;
            case (mem_bw)
                4'b1111: begin
                    size = size_4b;
                end
                4'b0011, 4'b1100: begin
                    size = size_2b;
                end
                4'b0001, 4'b0010, 4'b0100, 4'b1000: begin
                    size = size_1b;
                end
                default: begin
                    // unaligned or three byte pattern
                    size = size_0b;
                    bad  = 1'b1;
                end
            endcase
        end else if (!mem_rd) begin
            // neither read nor write
            size = size_0b;
            bad  = 1'b1;
        end
    end

    assign op.start        = mem_op && !busy;
    assign op.is_store     = store;
    assign op.bad_be       = bad;
    assign op.req.rqtype   = rqtype;
    assign op.req.size     = size;
    assign op.req.address  = mem_addr;
    // load data is a don't care at the cache, so always swap
    assign op.req.data     = swap_bytes(mem_wdata);

    // the core only strobes while no transaction is in flight
    a_no_op_when_busy : assert property (@(posedge mem_op) !busy)
        else $error("memory operation strobed while the bridge is busy");

endmodule

`default_nettype wire

// File: hw/l15_txn_fsm.sv
// execute stage FSM, holds one request on the L1.5 port until accepted and takes the response
`timescale 1ns/1ps
`default_nettype none

module l15_txn_fsm (
    input  logic                  clk,
    input  logic                  nrst,
    mem_op_if.fsm                 op,
    l15_resp_if.fsm               resp,
    output logic                  core_l15_val,
    output l15_pkg::l15_rqtype_e  core_l15_rqtype,
    output l15_pkg::msg_size_e    core_l15_size,
    output logic [31:0]           core_l15_address,
    output logic [31:0]           core_l15_data,
    input  logic                  l15_core_ack,
    input  logic                  l15_core_header_ack,
    input  logic                  l15_core_val,
    input  logic [31:0]           l15_core_data_0,
    input  l15_pkg::l15_rettype_e l15_core_returntype,
    output logic                  busy,
    output logic                  reject
);
    import l15_pkg::*;

    typedef enum logic [1:0] {
        idle,
        issue,
        wait_resp
    } state_e;

    state_e   state;
    l15_req_t req_q;
    logic     is_store_q;
    logic     launch;
    logic     accept;

    // start is already gated by busy, so both only fire from idle
    assign launch = op.start && !op.bad_be;
    assign reject = op.start && op.bad_be;

    // header and payload both taken in the same cycle
    assign accept = core_l15_val && l15_core_ack && l15_core_header_ack;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (launch) begin
                        state <= issue;
                    end
                end
                issue: begin
                    if (accept) begin
                        state <= wait_resp;
                    end
                end
                wait_resp: begin
                    if (l15_core_val) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // request payload, held for the whole transaction
    always_ff @(posedge clk) begin
        if (launch) begin
            req_q      <= op.req;
            is_store_q <= op.is_store;
        end
    end

    assign core_l15_val     = (state == issue);
    assign busy             = (state != idle);
    assign core_l15_rqtype  = req_q.rqtype;
    assign core_l15_size    = req_q.size;
    assign core_l15_address = req_q.address;
    assign core_l15_data    = req_q.data;

    // response passes straight through to the result stage
    assign resp.capture  = (state == wait_resp) && l15_core_val;
    assign resp.data     = l15_core_data_0;
    assign resp.rettype  = l15_core_returntype;
    assign resp.is_store = is_store_q;

    // back-pressure keeps val up with the same request
    a_hold_until_accept : assert property (
        @(posedge clk) disable iff (!nrst)
        core_l15_val && !accept |=> core_l15_val && $stable({core_l15_rqtype, core_l15_size,
                                                             core_l15_address, core_l15_data})
    ) else $error("request dropped or changed before the cache accepted it");

    // cache must not answer a request it has not taken yet
    a_no_resp_in_issue : assert property (
        @(posedge clk) disable iff (!nrst)
        (state == issue) |-> !l15_core_val
    ) else $error("response seen before the request was accepted");

endmodule

`default_nettype wire

// File: hw/l15_resp_unpack.sv
// result stage, returns load data in core byte order and flags unexpected return types
`timescale 1ns/1ps
`default_nettype none

module l15_resp_unpack (
    input  logic        clk,
    input  logic        nrst,
    l15_resp_if.unpack  resp,
    input  logic        reject,
    output logic [31:0] piton_out,
    output logic        resp_err,
    output logic        done
);
    import l15_pkg::*;

    logic ret_bad;

    // a load expects load data back, a store expects its ack
    assign ret_bad = resp.is_store ? (resp.rettype != st_ack)
                                   : (resp.rettype != load_ret);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            done      <= 1'b0;
            resp_err  <= 1'b0;
            piton_out <= '0;
        end else begin
            done     <= resp.capture || reject;
            // error is a pulse that goes with done
            resp_err <= reject || (resp.capture && ret_bad);
            if (resp.capture && !resp.is_store) begin
                piton_out <= swap_bytes(resp.data);
            end
        end
    end

    // rejected operations never reach the cache
    a_capture_xor_reject : assert property (
        @(posedge clk) disable iff (!nrst)
        !(resp.capture && reject)
    ) else $error("response captured in the same cycle as a rejected operation");

endmodule

`default_nettype wire

// File: hw/core_l15_bridge.sv
// top level of the memory-stage bridge, core strobe interface on one side and L1.5 port on the other
`timescale 1ns/1ps
`default_nettype none

module core_l15_bridge (
    input  logic                        clk,
    input  logic                        nrst,

    // core memory stage
    input  logic [l15_pkg::addr_w-1:0]  mem_addr,
    input  logic [l15_pkg::data_w-1:0]  mem_wdata,
    input  logic                        mem_rd,
    input  logic [3:0]                  mem_bw,
    input  logic                        mem_op,
    output logic                        busy,
    output logic                        done,
    output logic [31:0]                 piton_out,
    output logic                        resp_err,

    // L1.5 request
    output logic                        core_l15_val,
    output l15_pkg::l15_rqtype_e        core_l15_rqtype,
    output l15_pkg::msg_size_e          core_l15_size,
    output logic [31:0]                 core_l15_address,
    output logic [31:0]                 core_l15_data,

    // L1.5 response
    input  logic                        l15_core_ack,
    input  logic                        l15_core_header_ack,
    input  logic                        l15_core_val,
    input  logic [31:0]                 l15_core_data_0,
    input  l15_pkg::l15_rettype_e       l15_core_returntype
);

    logic reject;

    mem_op_if   op_link ();
    l15_resp_if resp_link ();

    mem_req_decode mem_req_decode_inst (
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_bw    (mem_bw),
        .mem_op    (mem_op),
        .busy      (busy),
        .op        (op_link.decode)
    );

    l15_txn_fsm l15_txn_fsm_inst (
        .clk                 (clk),
        .nrst                (nrst),
        .op                  (op_link.fsm),
        .resp                (resp_link.fsm),
        .core_l15_val        (core_l15_val),
        .core_l15_rqtype     (core_l15_rqtype),
        .core_l15_size       (core_l15_size),
        .core_l15_address    (core_l15_address),
        .core_l15_data       (core_l15_data),
        .l15_core_ack        (l15_core_ack),
        .l15_core_header_ack (l15_core_header_ack),
        .l15_core_val        (l15_core_val),
        .l15_core_data_0     (l15_core_data_0),
        .l15_core_returntype (l15_core_returntype),
        .busy                (busy),
        .reject              (reject)
    );

    l15_resp_unpack l15_resp_unpack_inst (
        .clk       (clk),
        .nrst      (nrst),
        .resp      (resp_link.unpack),
        .reject    (reject),
        .piton_out (piton_out),
        .resp_err  (resp_err),
        .done      (done)
    );

endmodule

`default_nettype wire

// File: test/tb_core_l15_bridge.sv
// table-driven testbench for the core to L1.5 bridge, with a cache responder model
`timescale 1ns/1ps
`default_nettype none

module tb_core_l15_bridge;
    import l15_pkg::*;

    localparam time clk_half     = 20ns;
    localparam int  idle_timeout = 50;
    localparam int  val_timeout  = 20;
    localparam int  done_timeout = 100;

    // one operation and what the bridge should make of it
    typedef struct packed {
        logic         rd;
        logic [3:0]   bw;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        logic [7:0]   ack_delay;
        logic [7:0]   resp_delay;
        l15_rettype_e ret;
        logic [31:0]  word;
        logic         has_req;
        l15_req_t     req;
        logic [31:0]  exp_out;
        logic         exp_err;
    } row_t;

    logic         clk;
    logic         nrst;
    logic [31:0]  mem_addr;
    logic [31:0]  mem_wdata;
    logic         mem_rd;
    logic [3:0]   mem_bw;
    logic         mem_op;
    logic         busy;
    logic         done;
    logic [31:0]  piton_out;
    logic         resp_err;
    logic         core_l15_val;
    l15_rqtype_e  core_l15_rqtype;
    msg_size_e    core_l15_size;
    logic [31:0]  core_l15_address;
    logic [31:0]  core_l15_data;
    logic         l15_core_ack;
    logic         l15_core_header_ack;
    logic         l15_core_val;
    logic [31:0]  l15_core_data_0;
    l15_rettype_e l15_core_returntype;

    row_t  rows[$];
    string row_names[$];

    // handoff from the main sequence to the cache model
    logic         serve_pending;
    string        serve_name;
    l15_req_t     serve_req;
    int           serve_ack_delay;
    int           serve_resp_delay;
    l15_rettype_e serve_ret;
    logic [31:0]  serve_word;

    logic [31:0] rnd_state = 32'h2ad;
    int mismatch_count = 0;
    int timeout_count  = 0;
    int protocol_count = 0;
    int accept_count   = 0;
    int request_count  = 0;
    logic val_prev     = 1'b0;

    core_l15_bridge core_l15_bridge_inst (
        .clk                 (clk),
        .nrst                (nrst),
        .mem_addr            (mem_addr),
        .mem_wdata           (mem_wdata),
        .mem_rd              (mem_rd),
        .mem_bw              (mem_bw),
        .mem_op              (mem_op),
        .busy                (busy),
        .done                (done),
        .piton_out           (piton_out),
        .resp_err            (resp_err),
        .core_l15_val        (core_l15_val),
        .core_l15_rqtype     (core_l15_rqtype),
        .core_l15_size       (core_l15_size),
        .core_l15_address    (core_l15_address),
        .core_l15_data       (core_l15_data),
        .l15_core_ack        (l15_core_ack),
        .l15_core_header_ack (l15_core_header_ack),
        .l15_core_val        (l15_core_val),
        .l15_core_data_0     (l15_core_data_0),
        .l15_core_returntype (l15_core_returntype)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_req(input string name, input l15_req_t exp, input l15_req_t act);
        if (act !== exp) begin
            $display("FAILED %s request: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_result(input string name, input logic [31:0] exp_out,
                                input logic exp_err, input logic [31:0] act_out,
                                input logic act_err);
        if (act_out !== exp_out || act_err !== exp_err) begin
            $display("FAILED %s result: expected out=%h err=%b, actual out=%h err=%b",
                     name, exp_out, exp_err, act_out, act_err);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %b, actual %b", name, what, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic add_row(input string name, input logic rd, input logic [3:0] bw,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input int ack_delay, input int resp_delay, input l15_rettype_e ret,
                           input logic [31:0] word, input logic has_req, input l15_rqtype_e rq,
                           input msg_size_e size, input logic [31:0] exp_data,
                           input logic [31:0] exp_out, input logic exp_err);
        row_t r;
        r.rd         = rd;
        r.bw         = bw;
        r.addr       = addr;
        r.wdata      = wdata;
        r.ack_delay  = ack_delay[7:0];
        r.resp_delay = resp_delay[7:0];
        r.ret        = ret;
        r.word       = word;
        r.has_req    = has_req;
        r.req        = {rq, size, addr, exp_data};
        r.exp_out    = exp_out;
        r.exp_err    = exp_err;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    // fields on the cache port at this edge against the expected request
    task automatic check_held_request();
        l15_req_t seen;
        seen = {core_l15_rqtype, core_l15_size, core_l15_address, core_l15_data};
        if (!core_l15_val) begin
            $display("%s: request valid dropped before the cache accepted it", serve_name);
            protocol_count++;
        end
        check_req(serve_name, serve_req, seen);
    endtask

    // plays the cache for one request
    task automatic serve_request();
        int waited;
        int hold;
        waited = 0;
        while (!core_l15_val && waited < val_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (!core_l15_val) begin
            $display("timeout: %s raised no request on the cache port", serve_name);
            timeout_count++;
            return;
        end
        rnd_state = xorshift32(rnd_state);
        hold = serve_ack_delay + int'(rnd_state % 4);
        for (int i = 0; i <= hold; i++) begin
            check_held_request();
            if (i == hold) begin
                l15_core_ack        <= 1'b1;
                l15_core_header_ack <= 1'b1;
            end
            @(posedge clk);
        end
        // acceptance edge
        check_held_request();
        l15_core_ack        <= 1'b0;
        l15_core_header_ack <= 1'b0;
        repeat (serve_resp_delay) @(posedge clk);
        l15_core_val        <= 1'b1;
        l15_core_data_0     <= serve_word;
        l15_core_returntype <= serve_ret;
        @(posedge clk);
        l15_core_val <= 1'b0;
    endtask

    initial begin : cache_model
        forever begin
            @(posedge clk);
            if (serve_pending) begin
                serve_pending <= 1'b0;
                serve_request();
            end
        end
    end

    // requests raised and accepted on the cache port
    always @(posedge clk) begin
        if (core_l15_val && !val_prev) begin
            request_count++;
        end
        if (core_l15_val && l15_core_ack && l15_core_header_ack) begin
            accept_count++;
        end
        val_prev = core_l15_val;
    end

    task automatic run_row(input int idx);
        row_t  r;
        string name;
        int    waited;
        int    acc_before;
        int    req_before;
        r    = rows[idx];
        name = row_names[idx];
        waited = 0;
        @(posedge clk);
        while (busy && waited < idle_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (busy) begin
            $display("timeout: bridge still busy before %s", name);
            timeout_count++;
        end
        acc_before = accept_count;
        req_before = request_count;
        mem_rd    <= r.rd;
        mem_bw    <= r.bw;
        mem_addr  <= r.addr;
        mem_wdata <= r.wdata;
        mem_op    <= 1'b1;
        serve_name       <= name;
        serve_req        <= r.req;
        serve_ack_delay  <= int'(r.ack_delay);
        serve_resp_delay <= int'(r.resp_delay);
        serve_ret        <= r.ret;
        serve_word       <= r.word;
        serve_pending    <= r.has_req;
        @(posedge clk);
        mem_op <= 1'b0;
        waited = 0;
        while (waited < done_timeout) begin
            @(posedge clk);
            waited++;
            if (done) begin
                break;
            end
        end
        if (!done) begin
            $display("timeout: no done pulse for %s", name);
            timeout_count++;
            return;
        end
        check_result(name, r.exp_out, r.exp_err, piton_out, resp_err);
        if (r.has_req && (accept_count - acc_before != 1 || request_count - req_before != 1)) begin
            $display("%s: %0d requests raised and %0d accepted instead of one", name,
                     request_count - req_before, accept_count - acc_before);
            protocol_count++;
        end
        if (!r.has_req && (request_count != req_before || core_l15_val || waited != 1)) begin
            $display("%s: rejected operation reached the cache or done came late", name);
            protocol_count++;
        end
    endtask

    initial begin
        nrst                = 1'b0;
        mem_addr            = '0;
        mem_wdata           = '0;
        mem_rd              = 1'b0;
        mem_bw              = 4'b0000;
        mem_op              = 1'b0;
        l15_core_ack        = 1'b0;
        l15_core_header_ack = 1'b0;
        l15_core_val        = 1'b0;
        l15_core_data_0     = '0;
        l15_core_returntype = load_ret;
        serve_pending       = 1'b0;

        // loads, every legal store pattern, wrong return types, rejected enables
        add_row("load_word", 1'b1, 4'b0000, 32'h0000_1000, 32'h0, 0, 1, load_ret, 32'ha1b2_c3d4,
                1'b1, load_rq, size_4b, 32'h0, 32'hd4c3_b2a1, 1'b0);
        add_row("store_word", 1'b0, 4'b1111, 32'h0000_2004, 32'h1122_3344, 2, 0, st_ack, 32'h0,
                1'b1, store_rq, size_4b, 32'h4433_2211, 32'hd4c3_b2a1, 1'b0);
        add_row("store_half_lo", 1'b0, 4'b0011, 32'h0000_2008, 32'h0000_beef, 1, 2, st_ack, 32'h0,
                1'b1, store_rq, size_2b, 32'hefbe_0000, 32'hd4c3_b2a1, 1'b0);
        add_row("store_half_hi", 1'b0, 4'b1100, 32'h0000_200c, 32'hcafe_0000, 0, 1, st_ack, 32'h0,
                1'b1, store_rq, size_2b, 32'h0000_feca, 32'hd4c3_b2a1, 1'b0);
        add_row("store_byte0", 1'b0, 4'b0001, 32'h0000_3000, 32'h0000_00aa, 3, 0, st_ack, 32'h0,
                1'b1, store_rq, size_1b, 32'haa00_0000, 32'hd4c3_b2a1, 1'b0);
        add_row("store_byte1", 1'b0, 4'b0010, 32'h0000_3004, 32'h0000_bb00, 0, 0, st_ack, 32'h0,
                1'b1, store_rq, size_1b, 32'h00bb_0000, 32'hd4c3_b2a1, 1'b0);
        add_row("store_byte2", 1'b0, 4'b0100, 32'h0000_3008, 32'h00cc_0000, 2, 3, st_ack, 32'h0,
                1'b1, store_rq, size_1b, 32'h0000_cc00, 32'hd4c3_b2a1, 1'b0);
        add_row("store_byte3", 1'b0, 4'b1000, 32'h0000_300c, 32'hdd00_0000, 1, 1, st_ack, 32'h0,
                1'b1, store_rq, size_1b, 32'h0000_00dd, 32'hd4c3_b2a1, 1'b0);
        add_row("load_slow", 1'b1, 4'b0000, 32'h8000_0040, 32'h0, 5, 3, load_ret, 32'h0123_4567,
                1'b1, load_rq, size_4b, 32'h0, 32'h6745_2301, 1'b0);
        add_row("load_err_ret", 1'b1, 4'b0000, 32'h8000_0044, 32'h0, 1, 0, err_ret, 32'hffff_ffff,
                1'b1, load_rq, size_4b, 32'h0, 32'hffff_ffff, 1'b1);
        add_row("store_load_ret", 1'b0, 4'b1111, 32'h0000_4000, 32'h0102_0304, 0, 2, load_ret,
                32'h5555_aaaa, 1'b1, store_rq, size_4b, 32'h0403_0201, 32'hffff_ffff, 1'b1);
        add_row("bad_be_0101", 1'b0, 4'b0101, 32'h0000_5000, 32'h1234_5678, 0, 0, st_ack, 32'h0,
                1'b0, store_rq, size_0b, 32'h0, 32'hffff_ffff, 1'b1);
        add_row("bad_be_0111", 1'b1, 4'b0111, 32'h0000_5004, 32'h1234_5678, 0, 0, st_ack, 32'h0,
                1'b0, store_rq, size_0b, 32'h0, 32'hffff_ffff, 1'b1);
        add_row("no_read_no_write", 1'b0, 4'b0000, 32'h0000_5008, 32'h0, 0, 0, load_ret, 32'h0,
                1'b0, load_rq, size_0b, 32'h0, 32'hffff_ffff, 1'b1);
        add_row("load_after_reject", 1'b1, 4'b0000, 32'h0000_6000, 32'h0, 1, 2, load_ret,
                32'h89ab_cdef, 1'b1, load_rq, size_4b, 32'h0, 32'hefcd_ab89, 1'b0);

        repeat (3) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        check_flag("reset", "core_l15_val", 1'b0, core_l15_val);
        check_flag("reset", "busy", 1'b0, busy);
        check_flag("reset", "done", 1'b0, done);
        check_result("reset", 32'h0, 1'b0, piton_out, resp_err);

        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        repeat (2) @(posedge clk);

        $display("errors: %0d value, %0d timeout, %0d protocol",
                 mismatch_count, timeout_count, protocol_count);
        if (mismatch_count + timeout_count + protocol_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/l15_pkg.sv
hw/bridge_if.sv
hw/mem_req_decode.sv
hw/l15_txn_fsm.sv
hw/l15_resp_unpack.sv
hw/core_l15_bridge.sv
test/tb_core_l15_bridge.sv
